// ==== alu_compute_stage.sv ====
// ========================================
// compute stage of the execute ALU
// adder/comparator, logic unit, shifter,
// result select and word sign extension
// ========================================

`timescale 1ns/100ps

module alu_compute_stage
    import alu_pkg::*;
(
    alu_op_if.dst           ops,
    output logic [XLEN-1:0] next_result,
    output logic            next_less,
    output logic            next_zero
);

    logic [XLEN-1:0] b_in;
    logic [XLEN-1:0] sum;
    logic            carry;
    logic            overflow;
    logic [XLEN-1:0] shift_out;
    logic [XLEN-1:0] sel;

    // ========================================
    // adder and comparator
    // ========================================

    // subtract as a + ~b + 1
    assign b_in = ops.b ^ {XLEN{ops.subtract}};
    assign {carry, sum} = {1'b0, ops.a} + {1'b0, b_in} + {{XLEN{1'b0}}, ops.subtract};

    assign overflow = (ops.a[XLEN-1] == b_in[XLEN-1]) && (sum[XLEN-1] != ops.a[XLEN-1]);

    // no carry out of a subtract means a borrow
    assign next_less = ops.unsigned_cmp ? (carry ^ ops.subtract) : (overflow ^ sum[XLEN-1]);
    assign next_zero = (sum == '0);

    // shift amount from the low bits of b
    alu_shifter u_shifter (
        .din         (ops.a),
        .shamt       (ops.b[SHAMT_W-1:0]),
        .word        (ops.word),
        .shift_left  (ops.shift_left),
        .shift_arith (ops.shift_arith),
        .dout        (shift_out)
    );

    // ========================================
    // result select
    // ========================================
    always_comb begin
        case (ops.op)
            OP_ADD,
            OP_SUB:    sel = sum;
            OP_SLT,
            OP_SLTU:   sel = {{(XLEN-1){1'b0}}, next_less};
            OP_OR:     sel = ops.a | ops.b;
            OP_AND:    sel = ops.a & ops.b;
            OP_XOR:    sel = ops.a ^ ops.b;
            OP_SLL,
            OP_SRL,
            OP_SRA:    sel = shift_out;
            OP_PASS_B: sel = ops.b;
            // nop and multiply/divide give zero here
            default:   sel = '0;
        endcase
    end

    // word results are sign-extended from bit 31
    assign next_result = ops.word ? {{(XLEN-WORD_W){sel[WORD_W-1]}}, sel[WORD_W-1:0]} : sel;

endmodule

// ==== alu_decode_stage.sv ====
// ========================================
// decode stage of the execute ALU
// word cut of operands, datapath and
// multiply/divide control decode
// ========================================

`timescale 1ns/100ps

module alu_decode_stage
    import alu_pkg::*;
(
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    input  logic            word,
    alu_op_if.src           ops
);

    // word form keeps only the low half
    assign ops.a    = word ? {{(XLEN-WORD_W){1'b0}}, a[WORD_W-1:0]} : a;
    assign ops.b    = word ? {{(XLEN-WORD_W){1'b0}}, b[WORD_W-1:0]} : b;
    assign ops.op   = op;
    assign ops.word = word;

    // adder and shifter controls
    assign ops.subtract     = (op == OP_SUB) || (op == OP_SLT) || (op == OP_SLTU);
    assign ops.unsigned_cmp = (op == OP_SLTU);
    assign ops.shift_left   = (op == OP_SLL);
    assign ops.shift_arith  = (op == OP_SRA);

    // ========================================
    // multiply/divide request decode
    // ========================================
    always_comb begin
        ops.is_md      = 1'b1;
        ops.is_mul     = 1'b0;
        ops.mul_hi     = 1'b0;
        ops.mul_sign   = MUL_SIGN_UU;
        ops.div_signed = 1'b0;
        ops.is_rem     = 1'b0;
        case (op)
            OP_MUL: begin
                ops.is_mul   = 1'b1;
                ops.mul_sign = MUL_SIGN_SS;
            end
            OP_MULH: begin
                ops.is_mul   = 1'b1;
                ops.mul_hi   = 1'b1;
                ops.mul_sign = MUL_SIGN_SS;
            end
            OP_MULHSU: begin
                ops.is_mul   = 1'b1;
                ops.mul_hi   = 1'b1;
                ops.mul_sign = MUL_SIGN_SU;
            end
            OP_MULHU: begin
                ops.is_mul   = 1'b1;
                ops.mul_hi   = 1'b1;
            end
            OP_DIV:  ops.div_signed = 1'b1;
            OP_DIVU: ops.div_signed = 1'b0;
            OP_REM: begin
                ops.div_signed = 1'b1;
                ops.is_rem     = 1'b1;
            end
            OP_REMU: ops.is_rem = 1'b1;
            default: ops.is_md = 1'b0;
        endcase
    end

endmodule

// ==== alu_exec_top.sv ====
// ========================================
// execute ALU top level
// decode, compute and result stages
// ========================================

`timescale 1ns/100ps

module alu_exec_top
    import alu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            flush,

    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    input  logic            word,

    output logic            mul_valid,
    output logic            mulw,
    output logic [1:0]      mul_signed,
    output logic [XLEN-1:0] multiplicand,
    output logic [XLEN-1:0] multiplier,
    input  logic            mul_ready,
    input  logic            mul_out_valid,
    input  logic [XLEN-1:0] result_hi,
    input  logic [XLEN-1:0] result_lo,

    output logic            div_valid,
    output logic            divw,
    output logic            div_signed,
    output logic [XLEN-1:0] dividend,
    output logic [XLEN-1:0] divisor,
    input  logic            div_ready,
    input  logic            div_out_valid,
    input  logic [XLEN-1:0] quotient,
    input  logic [XLEN-1:0] remainder,

    output logic            alu_valid,
    output logic [XLEN-1:0] result,
    output logic            less,
    output logic            zero
);

    logic [XLEN-1:0] next_result;
    logic            next_less;
    logic            next_zero;

    alu_op_if ops ();

    alu_decode_stage u_decode (
        .a    (a),
        .b    (b),
        .op   (op),
        .word (word),
        .ops  (ops.src)
    );

    alu_compute_stage u_compute (
        .ops         (ops.dst),
        .next_result (next_result),
        .next_less   (next_less),
        .next_zero   (next_zero)
    );

    alu_result_stage u_result (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .flush         (flush),
        .ops           (ops.dst),
        .next_result   (next_result),
        .next_less     (next_less),
        .next_zero     (next_zero),
        .mul_valid     (mul_valid),
        .mulw          (mulw),
        .mul_signed    (mul_signed),
        .multiplicand  (multiplicand),
        .multiplier    (multiplier),
        .mul_ready     (mul_ready),
        .mul_out_valid (mul_out_valid),
        .result_hi     (result_hi),
        .result_lo     (result_lo),
        .div_valid     (div_valid),
        .divw          (divw),
        .div_signed    (div_signed),
        .dividend      (dividend),
        .divisor       (divisor),
        .div_ready     (div_ready),
        .div_out_valid (div_out_valid),
        .quotient      (quotient),
        .remainder     (remainder),
        .alu_valid     (alu_valid),
        .result        (result),
        .less          (less),
        .zero          (zero)
    );

endmodule

// ==== alu_op_if.sv ====
// ========================================
// decoded operands and controls
// from decode to compute and result stages
// ========================================

`timescale 1ns/100ps

interface alu_op_if
    import alu_pkg::*;
();

    // word-cut operands
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    alu_op_e         op;
    logic            word;

    // datapath controls
    logic            subtract;
    logic            unsigned_cmp;
    logic            shift_left;
    logic            shift_arith;

    // multiply/divide request controls
    logic            is_md;
    logic            is_mul;
    logic            mul_hi;
    logic [1:0]      mul_sign;
    logic            div_signed;
    logic            is_rem;

    modport src (
        output a, b, op, word, subtract, unsigned_cmp, shift_left, shift_arith,
        output is_md, is_mul, mul_hi, mul_sign, div_signed, is_rem
    );

    modport dst (
        input a, b, op, word, subtract, unsigned_cmp, shift_left, shift_arith,
        input is_md, is_mul, mul_hi, mul_sign, div_signed, is_rem
    );

endinterface

// ==== alu_pkg.sv ====
// ========================================
// shared definitions of the execute ALU
// widths, opcode and sequencer enums,
// multiplier sign modes
// ========================================

package alu_pkg;

    // ========================================
    // widths
    // ========================================
    localparam int XLEN         = 64;
    localparam int WORD_W       = 32;
    localparam int SHAMT_W      = 6;
    localparam int SHAMT_WORD_W = 5;

    // ========================================
    // opcodes
    // ========================================
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_OR,
        OP_AND,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_PASS_B,
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } alu_op_e;

    // ========================================
    // multiply/divide sequencer
    // ========================================
    typedef enum logic [1:0] {
        // no request pending
        ST_IDLE,
        // valid raised, waiting for ready
        ST_REQUEST,
        // accepted, waiting for the result
        ST_WAIT
    } md_state_e;

    // multiplier sign mode, {a signed, b signed}
    localparam logic [1:0] MUL_SIGN_UU = 2'b00;
    localparam logic [1:0] MUL_SIGN_SU = 2'b10;
    localparam logic [1:0] MUL_SIGN_SS = 2'b11;

endpackage

// ==== alu_result_stage.sv ====
// ========================================
// result stage of the execute ALU
// multiply/divide sequencer, request
// registers, registered result and flags
// ========================================

`timescale 1ns/100ps

module alu_result_stage
    import alu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            flush,

    alu_op_if.dst           ops,
    input  logic [XLEN-1:0] next_result,
    input  logic            next_less,
    input  logic            next_zero,

    // multiplier
    output logic            mul_valid,
    output logic            mulw,
    output logic [1:0]      mul_signed,
    output logic [XLEN-1:0] multiplicand,
    output logic [XLEN-1:0] multiplier,
    input  logic            mul_ready,
    input  logic            mul_out_valid,
    input  logic [XLEN-1:0] result_hi,
    input  logic [XLEN-1:0] result_lo,

    // divider
    output logic            div_valid,
    output logic            divw,
    output logic            div_signed,
    output logic [XLEN-1:0] dividend,
    output logic [XLEN-1:0] divisor,
    input  logic            div_ready,
    input  logic            div_out_valid,
    input  logic [XLEN-1:0] quotient,
    input  logic [XLEN-1:0] remainder,

    output logic            alu_valid,
    output logic [XLEN-1:0] result,
    output logic            less,
    output logic            zero
);

    md_state_e       state;
    md_state_e       state_next;
    logic            clear;
    logic            simple_load;
    logic            md_start;
    logic            req_accept;
    logic            md_done;
    logic            is_mul_q;
    logic            mul_hi_q;
    logic            is_rem_q;
    logic            word_q;
    logic [XLEN-1:0] md_result;

    // flush only acts when not stalled
    assign clear       = rst || (flush && !stall);
    assign simple_load = (state == ST_IDLE) && !stall && !ops.is_md;
    assign md_start    = (state == ST_IDLE) && !stall && ops.is_md;
    assign req_accept  = (mul_valid && mul_ready) || (div_valid && div_ready);
    assign md_done     = (state == ST_WAIT) && (is_mul_q ? mul_out_valid : div_out_valid);

    // ========================================
    // sequencer
    // ========================================
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:    if (md_start) state_next = ST_REQUEST;
            ST_REQUEST: if (req_accept) state_next = ST_WAIT;
            ST_WAIT:    if (md_done) state_next = ST_IDLE;
            default:    state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // request fields, held until the next start
    always_ff @(posedge clk) begin
        if (clear) begin
            mulw         <= 1'b0;
            mul_signed   <= MUL_SIGN_UU;
            multiplicand <= '0;
            multiplier   <= '0;
            divw         <= 1'b0;
            div_signed   <= 1'b0;
            dividend     <= '0;
            divisor      <= '0;
            is_mul_q     <= 1'b0;
            mul_hi_q     <= 1'b0;
            is_rem_q     <= 1'b0;
            word_q       <= 1'b0;
        end else if (md_start) begin
            mulw         <= ops.word;
            mul_signed   <= ops.mul_sign;
            multiplicand <= ops.a;
            multiplier   <= ops.b;
            divw         <= ops.word;
            div_signed   <= ops.div_signed;
            dividend     <= ops.a;
            divisor      <= ops.b;
            is_mul_q     <= ops.is_mul;
            mul_hi_q     <= ops.mul_hi;
            is_rem_q     <= ops.is_rem;
            word_q       <= ops.word;
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            mul_valid <= 1'b0;
            div_valid <= 1'b0;
        end else if (md_start) begin
            mul_valid <= ops.is_mul;
            div_valid <= !ops.is_mul;
        end else if (req_accept) begin
            mul_valid <= 1'b0;
            div_valid <= 1'b0;
        end
    end

    // ========================================
    // result and flags
    // ========================================
    always_comb begin
        if (is_mul_q) begin
            if (mul_hi_q) begin
                md_result = result_hi;
            end else if (word_q) begin
                md_result = {{(XLEN-WORD_W){result_lo[WORD_W-1]}}, result_lo[WORD_W-1:0]};
            end else begin
                md_result = result_lo;
            end
        end else begin
            md_result = is_rem_q ? remainder : quotient;
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            alu_valid <= 1'b1;
        end else if (md_start) begin
            alu_valid <= 1'b0;
        end else if (md_done) begin
            alu_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            result <= '0;
            less   <= 1'b0;
            zero   <= 1'b0;
        end else if (simple_load) begin
            result <= next_result;
            less   <= next_less;
            zero   <= next_zero;
        end else if (md_done) begin
            result <= md_result;
        end
    end

    // ========================================
    // assertions
    // ========================================
    a_one_unit: assert property (@(posedge clk) disable iff (rst)
        !(mul_valid && div_valid));

    a_mul_hold: assert property (@(posedge clk) disable iff (rst)
        mul_valid && !mul_ready && !clear |=>
            mul_valid && $stable({mulw, mul_signed, multiplicand, multiplier}));

    a_div_hold: assert property (@(posedge clk) disable iff (rst)
        div_valid && !div_ready && !clear |=>
            div_valid && $stable({divw, div_signed, dividend, divisor}));

    a_busy: assert property (@(posedge clk) disable iff (rst)
        alu_valid == (state == ST_IDLE));

endmodule

// ==== alu_shifter.sv ====
// ========================================
// barrel shifter, 64-bit and word form
// left, logical right, arithmetic right
// ========================================

`timescale 1ns/100ps

module alu_shifter
    import alu_pkg::*;
(
    input  logic [XLEN-1:0]    din,
    input  logic [SHAMT_W-1:0] shamt,
    input  logic               word,
    input  logic               shift_left,
    input  logic               shift_arith,
    output logic [XLEN-1:0]    dout
);

    logic [SHAMT_WORD_W-1:0] shamt_w;
    logic [WORD_W-1:0]       din_w;
    logic [XLEN-1:0]         dw_out;
    logic [WORD_W-1:0]       w_out;

    // word form uses only 5 bits of the amount
    assign shamt_w = shamt[SHAMT_WORD_W-1:0];
    assign din_w   = din[WORD_W-1:0];

    // full width
    always_comb begin
        if (shift_left) begin
            dw_out = din << shamt;
        end else if (shift_arith) begin
            dw_out = $signed(din) >>> shamt;
        end else begin
            dw_out = din >> shamt;
        end
    end

    // word width, fill from bit 31
    always_comb begin
        if (shift_left) begin
            w_out = din_w << shamt_w;
        end else if (shift_arith) begin
            w_out = $signed(din_w) >>> shamt_w;
        end else begin
            w_out = din_w >> shamt_w;
        end
    end

    assign dout = word ? {{(XLEN-WORD_W){w_out[WORD_W-1]}}, w_out} : dw_out;

endmodule

// ==== list.f ====
+incdir+.
alu_pkg.sv
alu_op_if.sv
alu_decode_stage.sv
alu_shifter.sv
alu_compute_stage.sv
alu_result_stage.sv
alu_exec_top.sv
tb_alu_exec.sv

// ==== tb_alu_ref.svh ====
// ========================================
// testbench helpers for the execute ALU
// xorshift generator, reference model,
// typed compare tasks
// ========================================

logic [63:0] rng_state = 64'd87187;

function automatic logic [63:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
endfunction

// word form sees only the low half, zero-extended
function automatic logic [XLEN-1:0] cut(input logic w, input logic [XLEN-1:0] x);
    return w ? {{(XLEN-WORD_W){1'b0}}, x[WORD_W-1:0]} : x;
endfunction

function automatic logic [1:0] mul_mode(input alu_op_e o);
    case (o)
        OP_MUL, OP_MULH: return MUL_SIGN_SS;
        OP_MULHSU:       return MUL_SIGN_SU;
        default:         return MUL_SIGN_UU;
    endcase
endfunction

// full 128-bit product, operands extended per sign mode
function automatic logic [2*XLEN-1:0] product(input logic [1:0] sgn,
                                              input logic [XLEN-1:0] x,
                                              input logic [XLEN-1:0] y);
    logic [2*XLEN-1:0] px;
    logic [2*XLEN-1:0] py;
    px = sgn[1] ? {{XLEN{x[XLEN-1]}}, x} : {{XLEN{1'b0}}, x};
    py = sgn[0] ? {{XLEN{y[XLEN-1]}}, y} : {{XLEN{1'b0}}, y};
    return px * py;
endfunction

// RISC-V divide, including divide by zero and overflow
function automatic logic [XLEN-1:0] divide(input logic sgn, input logic w,
                                           input logic [XLEN-1:0] x,
                                           input logic [XLEN-1:0] y,
                                           input logic want_rem);
    logic signed [XLEN-1:0] sx;
    logic signed [XLEN-1:0] sy;
    logic [XLEN-1:0]        q;
    logic [XLEN-1:0]        r;
    sx = x;
    sy = y;
    if (w) begin
        sx = sgn ? {{(XLEN-WORD_W){x[WORD_W-1]}}, x[WORD_W-1:0]} : cut(1'b1, x);
        sy = sgn ? {{(XLEN-WORD_W){y[WORD_W-1]}}, y[WORD_W-1:0]} : cut(1'b1, y);
    end
    if (sy == 0) begin
        q = '1;
        r = sx;
    end else if (sgn && sx == {1'b1, {(XLEN-1){1'b0}}} && sy == '1) begin
        q = sx;
        r = '0;
    end else if (sgn) begin
        q = sx / sy;
        r = sx % sy;
    end else begin
        q = $unsigned(sx) / $unsigned(sy);
        r = $unsigned(sx) % $unsigned(sy);
    end
    if (w) begin
        q = {{(XLEN-WORD_W){q[WORD_W-1]}}, q[WORD_W-1:0]};
        r = {{(XLEN-WORD_W){r[WORD_W-1]}}, r[WORD_W-1:0]};
    end
    return want_rem ? r : q;
endfunction

function automatic void ref_alu(input alu_op_e o, input logic w,
                                input logic [XLEN-1:0] x, input logic [XLEN-1:0] y,
                                output logic [XLEN-1:0] res, output logic lt,
                                output logic eq);
    logic [XLEN-1:0]    ca;
    logic [XLEN-1:0]    cb;
    logic [SHAMT_W-1:0] sh;
    logic [WORD_W-1:0]  t;
    logic [2*XLEN-1:0]  p;
    ca = cut(w, x);
    cb = cut(w, y);
    sh = w ? {1'b0, cb[SHAMT_WORD_W-1:0]} : cb[SHAMT_W-1:0];
    lt = (o == OP_SLTU) ? (ca < cb) : ($signed(ca) < $signed(cb));
    eq = (ca == cb);
    p  = product(mul_mode(o), ca, cb);
    case (o)
        OP_ADD:    res = ca + cb;
        OP_SUB:    res = ca - cb;
        OP_SLT,
        OP_SLTU:   res = {{(XLEN-1){1'b0}}, lt};
        OP_OR:     res = ca | cb;
        OP_AND:    res = ca & cb;
        OP_XOR:    res = ca ^ cb;
        OP_PASS_B: res = cb;
        OP_MUL:    res = p[XLEN-1:0];
        OP_MULH,
        OP_MULHSU,
        OP_MULHU:  res = p[2*XLEN-1:XLEN];
        OP_DIV:    res = divide(1'b1, w, ca, cb, 1'b0);
        OP_DIVU:   res = divide(1'b0, w, ca, cb, 1'b0);
        OP_REM:    res = divide(1'b1, w, ca, cb, 1'b1);
        OP_REMU:   res = divide(1'b0, w, ca, cb, 1'b1);
        OP_SLL: begin
            t   = ca[WORD_W-1:0] << sh;
            res = w ? {{(XLEN-WORD_W){1'b0}}, t} : ca << sh;
        end
        OP_SRL: begin
            t   = ca[WORD_W-1:0] >> sh;
            res = w ? {{(XLEN-WORD_W){1'b0}}, t} : ca >> sh;
        end
        OP_SRA: begin
            t = $signed(ca[WORD_W-1:0]) >>> sh;
            if (w) begin
                res = {{(XLEN-WORD_W){1'b0}}, t};
            end else begin
                res = $signed(ca) >>> sh;
            end
        end
        default:   res = '0;
    endcase
    if (w) begin
        res = {{(XLEN-WORD_W){res[WORD_W-1]}}, res[WORD_W-1:0]};
    end
endfunction

task automatic check_data(input string name, input logic [XLEN-1:0] expected,
                          input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
        $display("Error %s: expected %h actual %h", name, expected, actual);
        $display("*** TEST FAILED ***");
        $fatal(1, "data mismatch");
    end
endtask

task automatic check_mode(input string name, input logic [1:0] expected,
                          input logic [1:0] actual);
    if (actual !== expected) begin
        $display("Error %s: expected %b actual %b", name, expected, actual);
        $display("*** TEST FAILED ***");
        $fatal(1, "sign mode mismatch");
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("Error %s: expected %b actual %b", name, expected, actual);
        $display("*** TEST FAILED ***");
        $fatal(1, "flag mismatch");
    end
endtask

// ==== tb_alu_exec.sv ====
// ========================================
// testbench for the execute ALU
// stimulus, multiply/divide unit model,
// compare process and timeout
// ========================================

`timescale 1ns/100ps

module tb_alu_exec
    import alu_pkg::*;
();

    localparam int N_OPS = 300 + 80 + 6 + 2;
    localparam int LIMIT = N_OPS * 12 + 100;

    typedef struct {
        int              cyc;
        logic            md;
        logic            flags;
        alu_op_e         op;
        logic            word;
        logic [XLEN-1:0] res;
        logic            less;
        logic            zero;
    } exp_t;

    logic            clk;
    logic            rst;
    logic            stall;
    logic            flush;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    alu_op_e         op;
    logic            word;
    logic            mul_valid;
    logic            mulw;
    logic [1:0]      mul_signed;
    logic [XLEN-1:0] multiplicand;
    logic [XLEN-1:0] multiplier;
    logic            mul_ready;
    logic            mul_out_valid;
    logic [XLEN-1:0] result_hi;
    logic [XLEN-1:0] result_lo;
    logic            div_valid;
    logic            divw;
    logic            div_signed;
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
    logic            div_ready;
    logic            div_out_valid;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
    logic            alu_valid;
    logic [XLEN-1:0] result;
    logic            less;
    logic            zero;

    int              cyc;
    exp_t            exp_q[$];
    alu_op_e         cur_op;
    logic            cur_word;
    logic [XLEN-1:0] cur_a;
    logic [XLEN-1:0] cur_b;

    `include "tb_alu_ref.svh"

    alu_exec_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : timeout
        cyc = 0;
        forever begin
            @(posedge clk);
            cyc = cyc + 1;
            if (cyc > LIMIT) begin
                $display("timeout: the run went past %0d cycles", LIMIT);
                $display("*** TEST FAILED ***");
                $fatal(1, "timeout");
            end
        end
    end

    // ========================================
    // external multiplier and divider
    // ========================================
    initial begin : md_unit
        int                d;
        logic              is_mul;
        logic [2*XLEN-1:0] p;
        mul_ready     = 1'b0;
        mul_out_valid = 1'b0;
        result_hi     = '0;
        result_lo     = '0;
        div_ready     = 1'b0;
        div_out_valid = 1'b0;
        quotient      = '0;
        remainder     = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && (mul_valid || div_valid)) begin
                is_mul = mul_valid;
                // back-pressure
                d = next_rand() % 4;
                repeat (d) begin
                    @(posedge clk);
                    #1;
                end
                mul_ready = is_mul;
                div_ready = !is_mul;
                @(posedge clk);
                if (is_mul) begin
                    check_flag("mulw", cur_word, mulw);
                    check_mode("mul_signed", mul_mode(cur_op), mul_signed);
                    check_data("multiplicand", cur_a, multiplicand);
                    check_data("multiplier", cur_b, multiplier);
                    p = product(mul_signed, multiplicand, multiplier);
                end else begin
                    check_flag("divw", cur_word, divw);
                    check_flag("div_signed", cur_op == OP_DIV || cur_op == OP_REM, div_signed);
                    check_data("dividend", cur_a, dividend);
                    check_data("divisor", cur_b, divisor);
                end
                #1;
                mul_ready = 1'b0;
                div_ready = 1'b0;
                d = 1 + next_rand() % 6;
                repeat (d - 1) begin
                    @(posedge clk);
                    #1;
                end
                if (is_mul) begin
                    result_hi     = p[2*XLEN-1:XLEN];
                    result_lo     = p[XLEN-1:0];
                    mul_out_valid = 1'b1;
                end else begin
                    quotient      = divide(div_signed, divw, dividend, divisor, 1'b0);
                    remainder     = divide(div_signed, divw, dividend, divisor, 1'b1);
                    div_out_valid = 1'b1;
                end
                @(posedge clk);
                #1;
                mul_out_valid = 1'b0;
                div_out_valid = 1'b0;
            end
        end
    end

    // ========================================
    // compare process
    // ========================================
    initial begin : compare
        exp_t  e;
        logic  prev_valid;
        string name;
        prev_valid = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            if (exp_q.size() > 0) begin
                e    = exp_q[0];
                name = $sformatf("%s word=%0b", e.op.name(), e.word);
                if (!e.md && e.cyc == cyc - 1) begin
                    void'(exp_q.pop_front());
                    check_data(name, e.res, result);
                    if (e.flags) begin
                        check_flag({name, " less"}, e.less, less);
                        check_flag({name, " zero"}, e.zero, zero);
                    end
                end else if (e.md && alu_valid && !prev_valid) begin
                    void'(exp_q.pop_front());
                    check_data(name, e.res, result);
                end
            end
            prev_valid = alu_valid;
        end
    end

    // ========================================
    // stimulus
    // ========================================
    task automatic run_simple(input alu_op_e o, input logic w,
                              input logic [XLEN-1:0] x, input logic [XLEN-1:0] y);
        exp_t e;
        op   = o;
        word = w;
        a    = x;
        b    = y;
        ref_alu(o, w, x, y, e.res, e.less, e.zero);
        e.cyc   = cyc;
        e.md    = 1'b0;
        e.flags = (o == OP_SUB) || (o == OP_SLT) || (o == OP_SLTU);
        e.op    = o;
        e.word  = w;
        exp_q.push_back(e);
        @(posedge clk);
        #1;
    endtask

    // one cycle of the operation, then nop until done
    task automatic run_md(input alu_op_e o, input logic w,
                          input logic [XLEN-1:0] x, input logic [XLEN-1:0] y,
                          input logic expect_result);
        exp_t e;
        op       = o;
        word     = w;
        a        = x;
        b        = y;
        cur_op   = o;
        cur_word = w;
        cur_a    = cut(w, x);
        cur_b    = cut(w, y);
        ref_alu(o, w, x, y, e.res, e.less, e.zero);
        e.cyc   = cyc;
        e.md    = 1'b1;
        e.flags = 1'b0;
        e.op    = o;
        e.word  = w;
        if (expect_result) begin
            exp_q.push_back(e);
        end
        @(posedge clk);
        #1;
        op = OP_NOP;
        if (expect_result) begin
            while (!alu_valid) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    initial begin : driver
        logic [63:0]     r;
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
        logic [XLEN-1:0] held;
        alu_op_e         o;
        logic            w;
        int              k;
        rst   = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        a     = '0;
        b     = '0;
        op    = OP_NOP;
        word  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // state out of reset
        check_flag("reset alu_valid", 1'b1, alu_valid);
        check_flag("reset mul_valid", 1'b0, mul_valid);
        check_flag("reset div_valid", 1'b0, div_valid);
        check_data("reset result", '0, result);

        for (int i = 0; i < 300; i++) begin
            r = next_rand();
            k = r % 12;
            o = alu_op_e'(k);
            x = next_rand();
            y = (r[6:4] == 0) ? x : next_rand();
            run_simple(o, r[8], x, y);
        end

        for (int i = 0; i < 80; i++) begin
            r = next_rand();
            k = 12 + r % 8;
            o = alu_op_e'(k);
            w = r[8] && (o == OP_MUL || o >= OP_DIV);
            x = next_rand();
            y = next_rand();
            if (r[13:11] == 0) begin
                y = '0;
            end else if (r[13:11] == 1 && o >= OP_DIV) begin
                x = w ? 64'h8000_0000 : {1'b1, {(XLEN-1){1'b0}}};
                y = '1;
            end
            run_md(o, w, x, y, 1'b1);
        end

        // stall while idle
        held  = result;
        stall = 1'b1;
        for (int i = 0; i < 6; i++) begin
            k  = (i % 2) ? OP_DIV : OP_ADD;
            op = alu_op_e'(k);
            a  = next_rand();
            b  = next_rand();
            @(posedge clk);
            #1;
            check_data("stall result", held, result);
            check_flag("stall alu_valid", 1'b1, alu_valid);
            check_flag("stall mul_valid", 1'b0, mul_valid);
            check_flag("stall div_valid", 1'b0, div_valid);
        end
        stall = 1'b0;
        op    = OP_NOP;

        // flush while the multiplier is busy
        run_md(OP_MULHU, 1'b0, next_rand(), next_rand(), 1'b0);
        while (!mul_valid) begin
            @(posedge clk);
            #1;
        end
        while (mul_valid) begin
            @(posedge clk);
            #1;
        end
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        check_flag("flush alu_valid", 1'b1, alu_valid);
        check_flag("flush mul_valid", 1'b0, mul_valid);
        check_data("flush result", '0, result);
        repeat (8) @(posedge clk);
        #1;
        check_flag("late out_valid alu_valid", 1'b1, alu_valid);
        check_data("late out_valid result", '0, result);
        run_simple(OP_ADD, 1'b0, next_rand(), next_rand());

        @(posedge clk);
        #3;
        if (exp_q.size() != 0) begin
            $display("%0d expected results were never checked", exp_q.size());
            $display("*** TEST FAILED ***");
            $fatal(1, "unchecked results");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule
